/* include/l2_settings.svh */
`ifndef L2_SETTINGS_SVH
`define L2_SETTINGS_SVH

// cache geometry
`define L2_SETS        16
`define L2_SET_BITS    4
`define L2_WAYS        2
`define L2_WAY_BITS    1
`define WORDS_PER_LINE 4
`define WORD_OFF_BITS  2

// address split is tag, set, word offset, 2 byte bits
`define ADDR_BITS      32
`define L2_TAG_BITS    24

// request queue and starting credits per channel
`define CPU_Q_DEPTH    2
`define CPU_CREDITS    2
`define MEM_CREDITS    2
`define RSP_CREDITS    2

`endif

/* logic/l2_core.sv */
`timescale 1ns/1ns
`include "l2_settings.svh"

module l2_core (
    input  logic             clk,
    input  logic             rst_n_i,
    input  logic             cpu_req_valid_i,
    input  l2_pkg::cpu_req_t cpu_req_i,
    output logic             cpu_req_credit_o,
    output logic             rd_rsp_valid_o,
    output l2_pkg::rd_rsp_t  rd_rsp_o,
    input  logic             rd_rsp_credit_i,
    output logic             mem_req_valid_o,
    output l2_pkg::mem_req_t mem_req_o,
    input  logic             mem_req_credit_i,
    input  logic             mem_rsp_valid_i,
    input  l2_pkg::mem_rsp_t mem_rsp_i
);

    l2_pkg::lookup_in_t             lookup_in;
    l2_pkg::lookup_out_t            lookup_out;
    logic                           stall;
    logic                           fill_done;

    l2_pkg::l2_set_t                rd_set;
    l2_pkg::l2_tag_t [`L2_WAYS-1:0] rd_tags;
    l2_pkg::line_t [`L2_WAYS-1:0]   rd_lines;
    logic [`L2_WAYS-1:0]            rd_valid;
    logic [`L2_WAYS-1:0]            rd_dirty;
    l2_pkg::l2_way_t                rd_evict_way;

    // write hit port
    logic                           hit_wr_en;
    l2_pkg::l2_set_t                hit_wr_set;
    l2_pkg::l2_way_t                hit_wr_way;
    l2_pkg::l2_tag_t                hit_wr_tag;
    l2_pkg::line_t                  hit_wr_line;

    // refill port
    logic                           fill_wr_en;
    l2_pkg::l2_set_t                fill_set;
    l2_pkg::l2_way_t                fill_way;
    l2_pkg::l2_tag_t                fill_tag;
    l2_pkg::line_t                  fill_line;
    logic                           advance_evict;

    // hit writes and refills never share a cycle
    l2_pkg::l2_set_t                wr_set;
    l2_pkg::l2_way_t                wr_way;
    l2_pkg::l2_tag_t                wr_tag;
    l2_pkg::line_t                  wr_line;

    assign wr_set  = fill_wr_en ? fill_set : hit_wr_set;
    assign wr_way  = fill_wr_en ? fill_way : hit_wr_way;
    assign wr_tag  = fill_wr_en ? fill_tag : hit_wr_tag;
    assign wr_line = fill_wr_en ? fill_line : hit_wr_line;

    l2_input_decoder decode_u (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .cpu_req_valid_i  (cpu_req_valid_i),
        .cpu_req_i        (cpu_req_i),
        .stall_i          (stall),
        .cpu_req_credit_o (cpu_req_credit_o),
        .lookup_in_o      (lookup_in)
    );

    l2_lookup lookup_u (
        .clk            (clk),
        .rst_n_i        (rst_n_i),
        .lookup_in_i    (lookup_in),
        .stall_i        (stall),
        .rd_tags_i      (rd_tags),
        .rd_lines_i     (rd_lines),
        .rd_valid_i     (rd_valid),
        .rd_dirty_i     (rd_dirty),
        .rd_evict_way_i (rd_evict_way),
        .fill_done_i    (fill_done),
        .rd_set_o       (rd_set),
        .wr_en_o        (hit_wr_en),
        .wr_set_o       (hit_wr_set),
        .wr_way_o       (hit_wr_way),
        .wr_tag_o       (hit_wr_tag),
        .wr_line_o      (hit_wr_line),
        .lookup_out_o   (lookup_out)
    );

    l2_localmem localmem_u (
        .clk             (clk),
        .rst_n_i         (rst_n_i),
        .rd_set_i        (rd_set),
        .wr_en_i         (hit_wr_en | fill_wr_en),
        .wr_set_i        (wr_set),
        .wr_way_i        (wr_way),
        .wr_tag_i        (wr_tag),
        .wr_dirty_i      (!fill_wr_en),
        .wr_line_i       (wr_line),
        .advance_evict_i (advance_evict),
        .rd_tags_o       (rd_tags),
        .rd_lines_o      (rd_lines),
        .rd_valid_o      (rd_valid),
        .rd_dirty_o      (rd_dirty),
        .rd_evict_way_o  (rd_evict_way)
    );

    l2_miss_unit miss_u (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .lookup_out_i     (lookup_out),
        .rd_rsp_credit_i  (rd_rsp_credit_i),
        .mem_req_credit_i (mem_req_credit_i),
        .mem_rsp_valid_i  (mem_rsp_valid_i),
        .mem_rsp_i        (mem_rsp_i),
        .rd_rsp_valid_o   (rd_rsp_valid_o),
        .rd_rsp_o         (rd_rsp_o),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_o        (mem_req_o),
        .stall_o          (stall),
        .fill_done_o      (fill_done),
        .fill_wr_en_o     (fill_wr_en),
        .fill_set_o       (fill_set),
        .fill_way_o       (fill_way),
        .fill_tag_o       (fill_tag),
        .fill_line_o      (fill_line),
        .advance_evict_o  (advance_evict)
    );

endmodule

/* logic/l2_input_decoder.sv */
`timescale 1ns/1ns
`include "l2_settings.svh"

module l2_input_decoder (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               cpu_req_valid_i,
    input  l2_pkg::cpu_req_t   cpu_req_i,
    input  logic               stall_i,
    output logic               cpu_req_credit_o,
    output l2_pkg::lookup_in_t lookup_in_o
);

    // depth is a power of two so the pointers wrap on their own
    localparam int ptr_bits = $clog2(`CPU_Q_DEPTH);

    l2_pkg::cpu_req_t    queue [`CPU_Q_DEPTH];
    logic [ptr_bits-1:0] wr_ptr;
    logic [ptr_bits-1:0] rd_ptr;
    logic [ptr_bits:0]   count;
    logic                queue_empty;
    logic                move;
    logic                push;
    logic                pop;

    assign queue_empty = (count == '0);
    assign move = !stall_i && (!queue_empty || cpu_req_valid_i);
    assign pop  = move && !queue_empty;
    // an empty queue lets the request go straight into the stage register
    assign push = cpu_req_valid_i && !(move && queue_empty);

    always_ff @(posedge clk) begin
        if (push) begin
            queue[wr_ptr] <= cpu_req_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_ptr           <= '0;
            rd_ptr           <= '0;
            count            <= '0;
            lookup_in_o      <= '0;
            cpu_req_credit_o <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + (ptr_bits+1)'(push) - (ptr_bits+1)'(pop);
            if (!stall_i) begin
                lookup_in_o.valid <= move;
                lookup_in_o.req   <= queue_empty ? cpu_req_i : queue[rd_ptr];
            end
            // one credit per request handed on to lookup
            cpu_req_credit_o <= move;
        end
    end

endmodule

/* logic/l2_localmem.sv */
`timescale 1ns/1ns
`include "l2_settings.svh"

module l2_localmem (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  l2_pkg::l2_set_t                     rd_set_i,
    input  logic                                wr_en_i,
    input  l2_pkg::l2_set_t                     wr_set_i,
    input  l2_pkg::l2_way_t                     wr_way_i,
    input  l2_pkg::l2_tag_t                     wr_tag_i,
    input  logic                                wr_dirty_i,
    input  l2_pkg::line_t                       wr_line_i,
    input  logic                                advance_evict_i,
    output l2_pkg::l2_tag_t [`L2_WAYS-1:0]      rd_tags_o,
    output l2_pkg::line_t [`L2_WAYS-1:0]        rd_lines_o,
    output logic [`L2_WAYS-1:0]                 rd_valid_o,
    output logic [`L2_WAYS-1:0]                 rd_dirty_o,
    output l2_pkg::l2_way_t                     rd_evict_way_o
);

    l2_pkg::l2_tag_t      tags [`L2_WAYS][`L2_SETS];
    l2_pkg::line_t        lines [`L2_WAYS][`L2_SETS];
    logic [`L2_WAYS-1:0]  valid [`L2_SETS];
    logic [`L2_WAYS-1:0]  dirty [`L2_SETS];
    l2_pkg::l2_way_t      evict_way [`L2_SETS];

    // asynchronous read by set
    always_comb begin
        for (int w = 0; w < `L2_WAYS; w++) begin
            rd_tags_o[w]  = tags[w][rd_set_i];
            rd_lines_o[w] = lines[w][rd_set_i];
        end
    end

    assign rd_valid_o     = valid[rd_set_i];
    assign rd_dirty_o     = dirty[rd_set_i];
    assign rd_evict_way_o = evict_way[rd_set_i];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tags[wr_way_i][wr_set_i]  <= wr_tag_i;
            lines[wr_way_i][wr_set_i] <= wr_line_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < `L2_SETS; s++) begin
                valid[s]     <= '0;
                dirty[s]     <= '0;
                evict_way[s] <= '0;
            end
        end else if (wr_en_i) begin
            valid[wr_set_i][wr_way_i] <= 1'b1;
            dirty[wr_set_i][wr_way_i] <= wr_dirty_i;
            // refills alone move the round robin pointer
            if (advance_evict_i) begin
                evict_way[wr_set_i] <= evict_way[wr_set_i] + 1'b1;
            end
        end
    end

endmodule

/* logic/l2_lookup.sv */
`timescale 1ns/1ns
`include "l2_settings.svh"

module l2_lookup (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  l2_pkg::lookup_in_t             lookup_in_i,
    input  logic                           stall_i,
    input  l2_pkg::l2_tag_t [`L2_WAYS-1:0] rd_tags_i,
    input  l2_pkg::line_t [`L2_WAYS-1:0]   rd_lines_i,
    input  logic [`L2_WAYS-1:0]            rd_valid_i,
    input  logic [`L2_WAYS-1:0]            rd_dirty_i,
    input  l2_pkg::l2_way_t                rd_evict_way_i,
    input  logic                           fill_done_i,
    output l2_pkg::l2_set_t                rd_set_o,
    output logic                           wr_en_o,
    output l2_pkg::l2_set_t                wr_set_o,
    output l2_pkg::l2_way_t                wr_way_o,
    output l2_pkg::l2_tag_t                wr_tag_o,
    output l2_pkg::line_t                  wr_line_o,
    output l2_pkg::lookup_out_t            lookup_out_o
);

    localparam int word_bits = $bits(l2_pkg::word_t);

    l2_pkg::cpu_req_t          req;
    l2_pkg::cpu_req_t          req_q;
    logic                      active;
    l2_pkg::l2_tag_t           tag;
    l2_pkg::l2_set_t           set;
    logic [`WORD_OFF_BITS-1:0] off;
    logic                      hit;
    l2_pkg::l2_way_t           hit_way;
    l2_pkg::l2_way_t           victim;
    l2_pkg::line_t             merged;

    // after a refill the held miss is looked up again
    assign req    = fill_done_i ? req_q : lookup_in_i.req;
    assign active = fill_done_i || (!stall_i && lookup_in_i.valid);
    assign {tag, set, off} = req.addr[`ADDR_BITS-1:2];
    assign rd_set_o = set;

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        victim  = rd_evict_way_i;
        // walk down so the lowest invalid way wins
        for (int w = `L2_WAYS-1; w >= 0; w--) begin
            if (rd_valid_i[w] && rd_tags_i[w] == tag) begin
                hit     = 1'b1;
                hit_way = l2_pkg::l2_way_t'(w);
            end
            if (!rd_valid_i[w]) begin
                victim = l2_pkg::l2_way_t'(w);
            end
        end
        merged = rd_lines_i[hit_way];
        merged[off*word_bits +: word_bits] = req.wdata;
    end

    // write hit goes back dirty in this stage
    assign wr_en_o   = active && hit && req.write;
    assign wr_set_o  = set;
    assign wr_way_o  = hit_way;
    assign wr_tag_o  = tag;
    assign wr_line_o = merged;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            lookup_out_o <= '0;
            req_q        <= '0;
        end else if (fill_done_i || !stall_i) begin
            lookup_out_o.valid        <= active;
            lookup_out_o.write        <= req.write;
            lookup_out_o.hit          <= hit;
            lookup_out_o.way          <= hit ? hit_way : victim;
            lookup_out_o.set          <= set;
            lookup_out_o.tag          <= tag;
            lookup_out_o.off          <= off;
            lookup_out_o.word         <= rd_lines_i[hit_way][off*word_bits +: word_bits];
            lookup_out_o.victim_dirty <= rd_dirty_i[victim];
            lookup_out_o.victim_tag   <= rd_tags_i[victim];
            lookup_out_o.victim_line  <= rd_lines_i[victim];
            req_q                     <= req;
        end
    end

endmodule

/* logic/l2_miss_unit.sv */
`timescale 1ns/1ns
`include "l2_settings.svh"

module l2_miss_unit (
    input  logic                clk,
    input  logic                rst_n_i,
    input  l2_pkg::lookup_out_t lookup_out_i,
    input  logic                rd_rsp_credit_i,
    input  logic                mem_req_credit_i,
    input  logic                mem_rsp_valid_i,
    input  l2_pkg::mem_rsp_t    mem_rsp_i,
    output logic                rd_rsp_valid_o,
    output l2_pkg::rd_rsp_t     rd_rsp_o,
    output logic                mem_req_valid_o,
    output l2_pkg::mem_req_t    mem_req_o,
    output logic                stall_o,
    output logic                fill_done_o,
    output logic                fill_wr_en_o,
    output l2_pkg::l2_set_t     fill_set_o,
    output l2_pkg::l2_way_t     fill_way_o,
    output l2_pkg::l2_tag_t     fill_tag_o,
    output l2_pkg::line_t       fill_line_o,
    output logic                advance_evict_o
);

    localparam int rsp_w = $clog2(`RSP_CREDITS + 1);
    localparam int mem_w = $clog2(`MEM_CREDITS + 1);

    l2_pkg::miss_state_t state;
    logic [rsp_w-1:0]    rsp_cnt;
    logic [mem_w-1:0]    mem_cnt;
    logic                send_rsp;
    logic                send_mem;
    logic                miss_start;

    assign send_rsp = lookup_out_i.valid && lookup_out_i.hit && !lookup_out_i.write &&
                      rsp_cnt != '0;
    assign send_mem = (state == l2_pkg::miss_evict || state == l2_pkg::miss_fetch) &&
                      mem_cnt != '0;
    // the old miss stays in place through the write and fill_done cycles
    assign miss_start = state == l2_pkg::miss_idle && lookup_out_i.valid &&
                        !lookup_out_i.hit && !fill_wr_en_o && !fill_done_o;

    // held for the whole miss, or a read hit with no response credit
    assign stall_o = lookup_out_i.valid &&
                     (!lookup_out_i.hit || (!lookup_out_i.write && rsp_cnt == '0));

    assign fill_set_o      = lookup_out_i.set;
    assign fill_way_o      = lookup_out_i.way;
    assign fill_tag_o      = lookup_out_i.tag;
    assign advance_evict_o = fill_wr_en_o;

    always_ff @(posedge clk) begin
        if (send_rsp) begin
            rd_rsp_o.data <= lookup_out_i.word;
        end
        if (send_mem) begin
            mem_req_o.put  <= (state == l2_pkg::miss_evict);
            mem_req_o.addr <= (state == l2_pkg::miss_evict) ?
                              {lookup_out_i.victim_tag, lookup_out_i.set} :
                              {lookup_out_i.tag, lookup_out_i.set};
            mem_req_o.line <= lookup_out_i.victim_line;
        end
        if (state == l2_pkg::miss_fill && mem_rsp_valid_i) begin
            fill_line_o <= mem_rsp_i.line;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state           <= l2_pkg::miss_idle;
            rsp_cnt         <= rsp_w'(`RSP_CREDITS);
            mem_cnt         <= mem_w'(`MEM_CREDITS);
            rd_rsp_valid_o  <= 1'b0;
            mem_req_valid_o <= 1'b0;
            fill_wr_en_o    <= 1'b0;
            fill_done_o     <= 1'b0;
        end else begin
            rsp_cnt         <= rsp_cnt + rsp_w'(rd_rsp_credit_i) - rsp_w'(send_rsp);
            mem_cnt         <= mem_cnt + mem_w'(mem_req_credit_i) - mem_w'(send_mem);
            rd_rsp_valid_o  <= send_rsp;
            mem_req_valid_o <= send_mem;
            fill_wr_en_o    <= 1'b0;
            // lookup sees the new line one cycle after the write
            fill_done_o     <= fill_wr_en_o;
            case (state)
                l2_pkg::miss_idle: begin
                    if (miss_start) begin
                        state <= lookup_out_i.victim_dirty ? l2_pkg::miss_evict :
                                                             l2_pkg::miss_fetch;
                    end
                end
                l2_pkg::miss_evict: begin
                    if (send_mem) begin
                        state <= l2_pkg::miss_fetch;
                    end
                end
                l2_pkg::miss_fetch: begin
                    if (send_mem) begin
                        state <= l2_pkg::miss_fill;
                    end
                end
                l2_pkg::miss_fill: begin
                    if (mem_rsp_valid_i) begin
                        fill_wr_en_o <= 1'b1;
                        state        <= l2_pkg::miss_idle;
                    end
                end
                default: state <= l2_pkg::miss_idle;
            endcase
        end
    end

endmodule

/* logic/l2_pkg.sv */
`include "l2_settings.svh"

package l2_pkg;

    typedef logic [`ADDR_BITS-1:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [`WORDS_PER_LINE*$bits(word_t)-1:0] line_t;
    typedef logic [`L2_TAG_BITS-1:0] l2_tag_t;
    typedef logic [`L2_SET_BITS-1:0] l2_set_t;
    typedef logic [`L2_WAY_BITS-1:0] l2_way_t;
    typedef logic [`ADDR_BITS-`WORD_OFF_BITS-3:0] line_addr_t;

    typedef struct packed {
        logic  write;
        addr_t addr;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        word_t data;
    } rd_rsp_t;

    // put carries a dirty victim, otherwise a get
    typedef struct packed {
        logic       put;
        line_addr_t addr;
        line_t      line;
    } mem_req_t;

    typedef struct packed {
        line_t line;
    } mem_rsp_t;

    typedef struct packed {
        logic     valid;
        cpu_req_t req;
    } lookup_in_t;

    // way is the hit way on a hit, the victim way on a miss
    typedef struct packed {
        logic                     valid;
        logic                     write;
        logic                     hit;
        l2_way_t                  way;
        l2_set_t                  set;
        l2_tag_t                  tag;
        logic [`WORD_OFF_BITS-1:0] off;
        word_t                    word;
        logic                     victim_dirty;
        l2_tag_t                  victim_tag;
        line_t                    victim_line;
    } lookup_out_t;

    typedef enum logic [1:0] {
        miss_idle,
        miss_evict,
        miss_fetch,
        miss_fill
    } miss_state_t;

endpackage

/* run.sh */
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f sim.f --top-module l2_core_tb -o l2_sim
./obj_dir/l2_sim | tee sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
grep -q "TEST OK" sim.log

/* sim.f */
+incdir+include
logic/l2_pkg.sv
logic/l2_input_decoder.sv
logic/l2_localmem.sv
logic/l2_lookup.sv
logic/l2_miss_unit.sv
logic/l2_core.sv
test/l2_core_tb.sv

/* test/l2_core_tb.sv */
`timescale 1ns/1ns
`include "l2_settings.svh"

module l2_core_tb;

    typedef struct packed {
        logic             from_file;
        l2_pkg::cpu_req_t req;
    } op_t;

    logic             clk = 1'b0;
    logic             rst_n_i = 1'b0;
    logic             cpu_req_valid_i = 1'b0;
    l2_pkg::cpu_req_t cpu_req_i = '0;
    logic             cpu_req_credit_o;
    logic             rd_rsp_valid_o;
    l2_pkg::rd_rsp_t  rd_rsp_o;
    logic             rd_rsp_credit_i = 1'b0;
    logic             mem_req_valid_o;
    l2_pkg::mem_req_t mem_req_o;
    logic             mem_req_credit_i = 1'b0;
    logic             mem_rsp_valid_i = 1'b0;
    l2_pkg::mem_rsp_t mem_rsp_i = '0;

    logic [31:0]        tests [0:63];
    op_t                op_q [$];
    l2_pkg::word_t      exp_q [$];
    int                 rsp_due [$];
    int                 mem_due [$];
    // ideal memory by word address, and the memory model by line
    l2_pkg::word_t      shadow [l2_pkg::addr_t];
    l2_pkg::line_t      mem_lines [l2_pkg::line_addr_t];
    l2_pkg::line_addr_t fill_addr;
    int seed = 21839;
    int cyc = 0;
    int errors = 0;
    int timeouts = 0;
    int cpu_credits = `CPU_CREDITS;
    int rsp_avail = `RSP_CREDITS;
    int mem_avail = `MEM_CREDITS;
    int accepted = 0;
    int credits_back = 0;
    int gets = 0;
    int puts = 0;
    int max_delay = 0;
    int fill_due = 0;
    int lat_start = 0;
    int lat = 0;
    logic running = 1'b0;
    logic fill_pending = 1'b0;
    logic last_put = 1'b0;
    logic lat_armed = 1'b0;
    logic lat_done = 1'b0;
    logic check_puts = 1'b0;

    l2_core uut (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .cpu_req_valid_i  (cpu_req_valid_i),
        .cpu_req_i        (cpu_req_i),
        .cpu_req_credit_o (cpu_req_credit_o),
        .rd_rsp_valid_o   (rd_rsp_valid_o),
        .rd_rsp_o         (rd_rsp_o),
        .rd_rsp_credit_i  (rd_rsp_credit_i),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_o        (mem_req_o),
        .mem_req_credit_i (mem_req_credit_i),
        .mem_rsp_valid_i  (mem_rsp_valid_i),
        .mem_rsp_i        (mem_rsp_i)
    );

    initial begin
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    function automatic l2_pkg::word_t word_default(l2_pkg::addr_t addr);
        return addr ^ 32'hA5A50000;
    endfunction

    function automatic l2_pkg::word_t ideal_word(l2_pkg::addr_t addr);
        l2_pkg::addr_t wa;
        wa = {addr[31:2], 2'b00};
        return shadow.exists(wa) ? shadow[wa] : word_default(wa);
    endfunction

    function automatic l2_pkg::line_t line_default(l2_pkg::line_addr_t la);
        l2_pkg::line_t ln;
        for (int i = 0; i < `WORDS_PER_LINE; i++) begin
            ln[i*32 +: 32] = word_default({la, 2'(i), 2'b00});
        end
        return ln;
    endfunction

    function automatic l2_pkg::line_t ideal_line(l2_pkg::line_addr_t la);
        l2_pkg::line_t ln;
        for (int i = 0; i < `WORDS_PER_LINE; i++) begin
            ln[i*32 +: 32] = ideal_word({la, 2'(i), 2'b00});
        end
        return ln;
    endfunction

    function automatic int pick_delay();
        if (max_delay == 0) begin
            return 0;
        end
        return int'($unsigned($random(seed)) % (max_delay + 1));
    endfunction

    task automatic report_error(string msg);
        errors++;
        $display("[ERROR] %0t: %s", $time, msg);
    endtask

    // samples DUT outputs and drives all DUT inputs on the falling edge
    always @(negedge clk) begin : engine
        op_t           op;
        l2_pkg::word_t exp;
        if (running) begin
            if (cpu_req_credit_o) begin
                cpu_credits++;
                credits_back++;
            end
            if (rd_rsp_valid_o) begin
                assert (rsp_avail > 0) else report_error("response sent without a credit");
                rsp_avail--;
                rsp_due.push_back(cyc + pick_delay());
                assert (exp_q.size() > 0)
                    else report_error("read response with no read outstanding");
                if (exp_q.size() > 0) begin
                    exp = exp_q.pop_front();
                    assert (rd_rsp_o.data == exp) else report_error($sformatf(
                        "read data %h, expected %h", rd_rsp_o.data, exp));
                end
                if (lat_armed) begin
                    lat = cyc - lat_start + 1;
                    lat_done = 1'b1;
                end
            end
            if (mem_req_valid_o) begin
                assert (mem_avail > 0) else report_error("memory request without a credit");
                mem_avail--;
                mem_due.push_back(cyc + pick_delay());
                assert (!(last_put && mem_req_o.put)) else report_error("put not followed by get");
                last_put = mem_req_o.put;
                if (mem_req_o.put) begin
                    puts++;
                    if (check_puts) begin
                        assert (mem_req_o.line == ideal_line(mem_req_o.addr))
                            else report_error($sformatf("put of line %h carries %h",
                                mem_req_o.addr, mem_req_o.line));
                    end
                    mem_lines[mem_req_o.addr] = mem_req_o.line;
                end else begin
                    assert (!fill_pending) else report_error("second get while one is open");
                    gets++;
                    fill_pending = 1'b1;
                    fill_addr = mem_req_o.addr;
                    fill_due = cyc + 1 + pick_delay();
                end
            end
            rd_rsp_credit_i = 1'b0;
            if (rsp_due.size() > 0 && rsp_due[0] <= cyc) begin
                void'(rsp_due.pop_front());
                rd_rsp_credit_i = 1'b1;
                rsp_avail++;
            end
            mem_req_credit_i = 1'b0;
            if (mem_due.size() > 0 && mem_due[0] <= cyc) begin
                void'(mem_due.pop_front());
                mem_req_credit_i = 1'b1;
                mem_avail++;
            end
            mem_rsp_valid_i = 1'b0;
            if (fill_pending && cyc >= fill_due) begin
                mem_rsp_valid_i = 1'b1;
                mem_rsp_i.line = mem_lines.exists(fill_addr) ? mem_lines[fill_addr] :
                                                               line_default(fill_addr);
                fill_pending = 1'b0;
            end
            cpu_req_valid_i = 1'b0;
            if (op_q.size() > 0 && cpu_credits > 0) begin
                op = op_q.pop_front();
                cpu_credits--;
                accepted++;
                cpu_req_valid_i = 1'b1;
                cpu_req_i = op.req;
                if (op.req.write) begin
                    shadow[{op.req.addr[31:2], 2'b00}] = op.req.wdata;
                end else begin
                    exp_q.push_back(op.from_file ? op.req.wdata : ideal_word(op.req.addr));
                    if (lat_armed) begin
                        lat_start = cyc + 1;
                    end
                end
            end
        end
    end

    function automatic logic is_idle();
        return op_q.size() == 0 && exp_q.size() == 0 && !fill_pending &&
               rsp_due.size() == 0 && mem_due.size() == 0;
    endfunction

    // idle must hold for several cycles so a late write miss is seen
    task automatic wait_drained(string what);
        int n;
        int quiet;
        n = 0;
        quiet = 0;
        while (quiet < 8 && n < 5000) begin
            @(negedge clk);
            #1;
            quiet = is_idle() ? quiet + 1 : 0;
            n++;
        end
        if (quiet < 8) begin
            timeouts++;
            $display("timeout: %s did not drain within 5000 cycles", what);
        end
    endtask

    task automatic check_hit_latency();
        int n;
        lat_armed = 1'b1;
        lat_done = 1'b0;
        op_q.push_back({1'b0, 1'b0, 32'h00002004, 32'h0});
        n = 0;
        while (!lat_done && n < 200) begin
            @(negedge clk);
            #1;
            n++;
        end
        if (!lat_done) begin
            timeouts++;
            $display("timeout: hit read got no response within 200 cycles");
        end else begin
            assert (lat == 3) else report_error($sformatf("hit latency %0d, expected 3", lat));
        end
        lat_armed = 1'b0;
    endtask

    initial begin
        int           i;
        int           idx;
        logic [31:0]  r;
        l2_pkg::addr_t addr;
        $readmemh("test/l2_tests.txt", tests);
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        running = 1'b1;

        check_puts = 1'b1;
        i = 0;
        while (i < 21 && tests[3*i] != 32'hFFFFFFFF) begin
            op_q.push_back({1'b1, tests[3*i][0], tests[3*i+1], tests[3*i+2]});
            i++;
        end
        wait_drained("directed operations");
        assert (gets == 7) else report_error($sformatf("%0d gets, expected 7", gets));
        assert (puts == 2) else report_error($sformatf("%0d puts, expected 2", puts));

        check_hit_latency();
        wait_drained("hit latency read");
        assert (gets == 7) else report_error("hit read went to memory");

        // 48 lines over 16 sets forces evictions
        check_puts = 1'b0;
        max_delay = 4;
        repeat (300) begin
            r = $random(seed);
            idx = int'(r[15:0] % 16'd48);
            addr = {24'(32'h10 + idx / 16), 4'(idx % 16), r[9:8], 2'b00};
            op_q.push_back({1'b0, r[12], addr, 32'($random(seed))});
        end
        wait_drained("random phase");
        assert (credits_back == accepted) else report_error($sformatf(
            "%0d CPU credits back for %0d requests", credits_back, accepted));

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* test/l2_tests.txt */
// op (0 read, 1 write), byte address, write data or expected read data
// an op of ffffffff ends the list
00000000 00001000 a5a51000
00000001 00002004 12345678
00000000 00002004 12345678
00000000 00002008 a5a52008
00000001 00004010 deadbeef
00000001 00005014 cafef00d
00000000 00006018 a5a56018
00000000 00004010 deadbeef
00000000 00005014 cafef00d
ffffffff 00000000 00000000
